/* dv/pit_model.sv */
`timescale 1ns/1ns

module pit_model import pit_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic [num_chan-1:0] tick,
  input  logic [num_chan-1:0] gate,
  input  logic [num_chan-1:0] arm,
  input  logic [num_chan-1:0] load,
  input  logic [data_w-1:0]   cw,
  input  logic [cnt_w-1:0]    init_val,
  output logic [num_chan-1:0] out,
  output logic [cnt_w-1:0]    cnt [num_chan]
);

  pit_mode_e           md [num_chan];
  logic [cnt_w-1:0]    ini [num_chan];
  logic [num_chan-1:0] pend;
  logic [num_chan-1:0] ldd;
  logic [num_chan-1:0] run;
  logic [num_chan-1:0] gq;
  logic [num_chan-1:0] trg;

  // Codes above 5 fold onto the rate and square modes
  function automatic pit_mode_e decode_mode(input logic [data_w-1:0] w);
    logic [2:0] m;
    m = w[3:1];
    if (m > 3'd5) begin
      m = m - 3'd4;
    end
    return pit_mode_e'(m);
  endfunction

  always @(posedge clk) begin : step
    logic             rise;
    logic             fire;
    logic [cnt_w-1:0] nxt;
    for (int c = 0; c < num_chan; c++) begin
      rise = gate[c] && !gq[c];
      fire = trg[c] || rise;
      nxt  = cnt[c] - cnt_w'(1);
      if (rst) begin
        md[c]   = mode0_terminal;
        ini[c]  = '0;
        cnt[c]  = '0;
        out[c]  = 1'b1;
        pend[c] = 1'b0;
        ldd[c]  = 1'b0;
        run[c]  = 1'b0;
        trg[c]  = 1'b0;
      end else if (arm[c]) begin
        md[c]   = decode_mode(cw);
        out[c]  = (md[c] != mode0_terminal);
        pend[c] = 1'b0;
        ldd[c]  = 1'b0;
        run[c]  = 1'b0;
        trg[c]  = 1'b0;
      end else begin
        if (tick[c]) begin
          case (md[c])
            mode0_terminal, mode4_soft_strobe: begin
              if (md[c] == mode4_soft_strobe) out[c] = 1'b1;
              if (pend[c]) begin
                cnt[c]  = ini[c];
                run[c]  = 1'b1;
                pend[c] = 1'b0;
                if (md[c] == mode0_terminal) out[c] = 1'b0;
              end else if (run[c] && gate[c]) begin
                cnt[c] = nxt;
                if (nxt == '0) begin
                  out[c] = (md[c] == mode0_terminal);
                  run[c] = 1'b0;
                end
              end
            end
            mode1_oneshot, mode5_hard_strobe: begin
              if (md[c] == mode5_hard_strobe) out[c] = 1'b1;
              if (fire && ldd[c]) begin
                cnt[c]  = ini[c];
                run[c]  = 1'b1;
                pend[c] = 1'b0;
                if (md[c] == mode1_oneshot) out[c] = 1'b0;
              end else if (run[c]) begin
                cnt[c] = nxt;
                if (nxt == '0) begin
                  out[c] = (md[c] == mode1_oneshot);
                  run[c] = 1'b0;
                end
              end
            end
            default: begin
              // Rate and square wave share the start and gate rules
              if (pend[c] || (run[c] && !gate[c])) begin
                cnt[c]  = ini[c];
                out[c]  = 1'b1;
                run[c]  = 1'b1;
                pend[c] = 1'b0;
              end else if (run[c] && md[c] == mode2_rate) begin
                cnt[c] = (cnt[c] == cnt_w'(1)) ? ini[c] : nxt;
                out[c] = (cnt[c] != cnt_w'(1));
              end else if (run[c]) begin
                if (cnt[c] == cnt_w'(1) || cnt[c] == cnt_w'(2)) begin
                  cnt[c] = ini[c];
                  out[c] = !out[c];
                end else begin
                  cnt[c] = cnt[c] - cnt_w'(2);
                end
              end
            end
          endcase
        end
        if (load[c]) begin
          ini[c]  = init_val;
          pend[c] = 1'b1;
          ldd[c]  = 1'b1;
        end
        if (tick[c]) trg[c] = 1'b0;
        else if (rise) trg[c] = 1'b1;
      end
      gq[c] = rst ? 1'b0 : gate[c];
    end
  end

endmodule

/* dv/pit_tb.sv */
`timescale 1ns/1ns

module pit_tb import pit_pkg::*; ();

  localparam int len_mode0  = 300;
  localparam int len_rate   = 600;
  localparam int len_trig   = 500;
  localparam int len_fmt    = 80;
  localparam int len_latch  = 120;
  localparam int max_cycles = 8 + len_mode0 + len_rate + len_trig + len_fmt + len_latch + 1500;

  logic                clk = 1'b0;
  logic                rst;
  logic                wb_cyc;
  logic                wb_stb;
  logic                wb_we;
  logic [addr_w-1:0]   wb_adr;
  logic [data_w-1:0]   wb_dat_i;
  logic [data_w-1:0]   wb_dat_o;
  logic                wb_ack;
  logic [num_chan-1:0] tick;
  logic [num_chan-1:0] gate;
  logic [num_chan-1:0] out;

  logic [num_chan-1:0] m_arm;
  logic [num_chan-1:0] m_load;
  logic [data_w-1:0]   m_cw;
  logic [cnt_w-1:0]    m_init;
  logic [num_chan-1:0] m_out;
  logic [cnt_w-1:0]    m_cnt [num_chan];

  integer              seed;
  int                  errors;
  int                  checks;
  int                  cycles;
  logic [num_chan-1:0] tick_mask;
  logic [num_chan-1:0] tick_force;
  logic                chk_en;

  pit_top dut0 (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack   (wb_ack),
    .tick     (tick),
    .gate     (gate),
    .out      (out)
  );

  pit_model model0 (
    .clk      (clk),
    .rst      (rst),
    .tick     (tick),
    .gate     (gate),
    .arm      (m_arm),
    .load     (m_load),
    .cw       (m_cw),
    .init_val (m_init),
    .out      (m_out),
    .cnt      (m_cnt)
  );

  always #50 clk = ~clk;

  // Tick controls are sampled at the edge and ticks driven shortly after
  always @(posedge clk) begin : tick_drive
    logic [num_chan-1:0] mask_s;
    logic [num_chan-1:0] force_s;
    logic [31:0]         r;
    mask_s  = tick_mask;
    force_s = tick_force;
    r       = $random(seed);
    #5;
    tick = (r[num_chan-1:0] & mask_s) | force_s;
  end

  always @(negedge clk) begin
    if (chk_en) begin
      checks++;
      if (out !== m_out) begin
        errors++;
        $display("mismatch at %0t: out expected %b got %b", $time, m_out, out);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout: run did not finish within %0d clocks", max_cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic int rand_between(input int lo, input int hi);
    logic [31:0] r;
    r = $random(seed);
    return lo + int'(r[15:0]) % (hi - lo + 1);
  endfunction

  task automatic wait_clocks(input int n);
    repeat (n) begin
      @(posedge clk);
      #5;
    end
  endtask

  task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  // Ack is due on the first edge after the request
  task automatic wait_ack();
    int waits;
    waits = 1;
    @(posedge clk);
    #1;
    while (!wb_ack && waits < 2) begin
      @(posedge clk);
      #1;
      waits++;
    end
    checks++;
    if (!wb_ack) begin
      errors++;
      $display("no ack within 2 clocks of the request at %0t", $time);
    end else if (waits != 1) begin
      errors++;
      $display("ack came one clock late at %0t", $time);
    end
    #4;
  endtask

  task automatic bus_write(input logic [1:0] adr, input logic [7:0] dat);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_i = dat;
    wait_ack();
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_read(input logic [1:0] adr, output logic [7:0] dat);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    wait_ack();
    dat    = wb_dat_o;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wait_clocks(1);
  endtask

  // Snap is the model count on the edge a latch command takes effect
  task automatic write_control(input int ch, input logic [2:0] mode, input pit_access_e acc,
                               output logic [15:0] snap);
    logic [7:0] cw;
    cw = {2'(ch), 2'(acc), mode, 1'b0};
    bus_write(addr_ctrl, cw);
    snap = (ch < num_chan) ? m_cnt[ch] : 16'h0;
    m_cw = cw;
    if (acc != acc_latch && ch < num_chan) begin
      m_arm[ch] = 1'b1;
    end
    wait_clocks(1);
    m_arm = '0;
  endtask

  task automatic load_count(input int ch, input pit_access_e acc, input logic [15:0] val,
                            output logic [15:0] exp);
    case (acc)
      acc_lsb: begin
        exp = {8'h00, val[7:0]};
        bus_write(2'(ch), val[7:0]);
      end
      acc_msb: begin
        exp = {val[15:8], 8'h00};
        bus_write(2'(ch), val[15:8]);
      end
      default: begin
        exp = val;
        bus_write(2'(ch), val[7:0]);
        wait_clocks(1);
        bus_write(2'(ch), val[15:8]);
      end
    endcase
    m_init     = exp;
    m_load[ch] = 1'b1;
    wait_clocks(1);
    m_load = '0;
  endtask

  task automatic report_test(input int num, input string name, input int mark);
    $display("test %0d %s finished with %0d errors", num, name, errors - mark);
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  initial begin
    logic [7:0]  d;
    logic [15:0] s;
    logic [15:0] e;
    logic [15:0] snap;
    int          mark;
    pit_access_e fmts [3];
    seed = 32'hc2c9;
    {wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_i} = '0;
    {tick, gate, tick_mask, tick_force, m_arm, m_load} = '0;
    {m_cw, m_init} = '0;
    {errors, checks, cycles} = '0;
    chk_en = 1'b0;
    rst    = 1'b1;
    repeat (8) @(posedge clk);
    #5;
    rst    = 1'b0;
    chk_en = 1'b1;

    mark = errors;
    check_value("out", 16'(out), 16'h7);
    bus_read(addr_ctrl, d);
    check_value("wb_dat_o", 16'(d), 16'h0);
    write_control(3, 3'd0, acc_word, s);
    wait_clocks(4);
    check_value("out", 16'(out), 16'h7);
    report_test(1, "reset and bus timing", mark);

    mark = errors;
    gate = 3'b001;
    write_control(0, 3'd0, acc_word, s);
    load_count(0, acc_word, 16'(rand_between(5, 40)), e);
    tick_mask = 3'b001;
    repeat (len_mode0) begin
      wait_clocks(1);
      if (rand_between(0, 9) == 0) gate[0] = ~gate[0];
    end
    tick_mask = '0;
    report_test(2, "mode 0", mark);

    // Code 6 is an alias of mode 2
    mark = errors;
    gate = 3'b110;
    write_control(1, 3'd6, acc_word, s);
    write_control(2, 3'd3, acc_word, s);
    load_count(1, acc_word, 16'(rand_between(2, 17)), e);
    load_count(2, acc_word, 16'(rand_between(2, 17)), e);
    tick_mask = 3'b110;
    repeat (len_rate) begin
      wait_clocks(1);
      if (rand_between(0, 19) == 0) gate[1] = ~gate[1];
      if (rand_between(0, 19) == 0) gate[2] = ~gate[2];
    end
    tick_mask = '0;
    report_test(3, "modes 2 and 3", mark);

    mark = errors;
    gate = 3'b000;
    write_control(0, 3'd1, acc_word, s);
    write_control(1, 3'd5, acc_word, s);
    load_count(0, acc_word, 16'(rand_between(3, 20)), e);
    load_count(1, acc_word, 16'(rand_between(3, 20)), e);
    tick_mask = 3'b011;
    repeat (len_trig) begin
      wait_clocks(1);
      if (rand_between(0, 7) == 0) gate[0] = ~gate[0];
      if (rand_between(0, 7) == 0) gate[1] = ~gate[1];
    end
    tick_mask = '0;
    report_test(4, "modes 1 and 5", mark);

    // Gate low keeps the loaded count still for the reads
    mark = errors;
    gate = 3'b000;
    fmts = '{acc_lsb, acc_msb, acc_word};
    for (int f = 0; f < 3; f++) begin
      write_control(2, 3'd0, fmts[f], s);
      load_count(2, fmts[f], 16'(rand_between(0, 65535)), e);
      tick_force = 3'b100;
      wait_clocks(1);
      tick_force = '0;
      wait_clocks(3);
      bus_read(2'd2, d);
      check_value("wb_dat_o", 16'(d), (fmts[f] == acc_msb) ? 16'(e[15:8]) : 16'(e[7:0]));
      if (fmts[f] == acc_word) begin
        bus_read(2'd2, d);
        check_value("wb_dat_o", 16'(d), 16'(e[15:8]));
      end
    end
    report_test(5, "access formats", mark);

    mark = errors;
    gate = 3'b001;
    write_control(0, 3'd2, acc_word, s);
    load_count(0, acc_word, 16'(rand_between(100, 400)), e);
    tick_mask = 3'b001;
    wait_clocks(20);
    write_control(0, 3'd0, acc_latch, snap);
    wait_clocks(rand_between(3, 10));
    write_control(0, 3'd0, acc_latch, s);
    wait_clocks(rand_between(3, 10));
    bus_read(2'd0, d);
    check_value("wb_dat_o", 16'(d), 16'(snap[7:0]));
    bus_read(2'd0, d);
    check_value("wb_dat_o", 16'(d), 16'(snap[15:8]));
    tick_mask = '0;
    wait_clocks(4);
    report_test(6, "counter latch", mark);

    $display("checks=%0d errors=%0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* pit.f */
verilog/pit_pkg.sv
verilog/pit_chan_if.sv
verilog/pit_count_unit.sv
verilog/pit_channel.sv
verilog/pit_bus.sv
verilog/pit_top.sv
dv/pit_model.sv
dv/pit_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module pit_tb -f pit.f -o pit_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/pit_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF '*** FAILED ***' sim.log; then
  echo "simulation reported failure"
  exit 1
fi
exit 0

/* verilog/pit_bus.sv */
`timescale 1ns/1ns

module pit_bus import pit_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  logic [addr_w-1:0] wb_adr,
  input  logic [data_w-1:0] wb_dat_i,
  output logic [data_w-1:0] wb_dat_o,
  output logic              wb_ack,
  pit_chan_if.bus           ch [num_chan]
);

  logic              new_req;
  logic              is_ctrl;
  logic [data_w-1:0] rd_bytes [num_chan];
  logic [data_w-1:0] rd_mux;

  // Request seen with ack still low, answered on the next edge
  assign new_req = wb_cyc && wb_stb && !wb_ack;
  assign is_ctrl = (wb_adr == addr_ctrl);

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= new_req;
    end
  end

  // --------------------------------------------------
  // Read data return
  // --------------------------------------------------
  // Address 3 matches no channel and reads as zero
  always_comb begin
    rd_mux = '0;
    for (int k = 0; k < num_chan; k++) begin
      if (wb_adr == addr_w'(k)) begin
        rd_mux = rd_bytes[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (new_req && !wb_we) begin
      wb_dat_o <= rd_mux;
    end
  end

  // --------------------------------------------------
  // Per-channel strobes
  // --------------------------------------------------
  for (genvar i = 0; i < num_chan; i++) begin : g_ch
    assign rd_bytes[i] = ch[i].rdata;

    always_ff @(posedge clk) begin
      if (rst) begin
        ch[i].ctrl_wr <= 1'b0;
        ch[i].cnt_wr  <= 1'b0;
        ch[i].cnt_rd  <= 1'b0;
      end else begin
        // Select 3 is the read-back command and reaches no channel
        ch[i].ctrl_wr <= new_req && wb_we && is_ctrl && (ctl_sel(wb_dat_i) == 2'(i));
        ch[i].cnt_wr  <= new_req && wb_we && (wb_adr == addr_w'(i));
        ch[i].cnt_rd  <= new_req && !wb_we && (wb_adr == addr_w'(i));
      end
    end

    always_ff @(posedge clk) begin
      if (new_req && wb_we) begin
        ch[i].wdata <= wb_dat_i;
      end
    end
  end

endmodule

/* verilog/pit_chan_if.sv */
`timescale 1ns/1ns

interface pit_chan_if import pit_pkg::*; ();

  // One-clock strobes from the bus, never two at once
  logic ctrl_wr;
  logic cnt_wr;
  logic cnt_rd;

  // Byte from the host
  logic [data_w-1:0] wdata;

  // Next read byte due from this channel
  logic [data_w-1:0] rdata;

  modport bus (
    output ctrl_wr,
    output cnt_wr,
    output cnt_rd,
    output wdata,
    input  rdata
  );

  modport chan (
    input  ctrl_wr,
    input  cnt_wr,
    input  cnt_rd,
    input  wdata,
    output rdata
  );

endinterface

/* verilog/pit_channel.sv */
`timescale 1ns/1ns

module pit_channel import pit_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  pit_chan_if.chan bus,
  input  logic     tick,
  input  logic     gate,
  output logic     out
);

  pit_mode_e        mode_q;
  pit_mode_e        mode_cur;
  pit_access_e      acc_q;
  pit_access_e      acc_new;
  logic [cnt_w-1:0] init_q;
  logic [cnt_w-1:0] latch_q;
  logic [cnt_w-1:0] count;
  logic [cnt_w-1:0] rd_src;
  logic             wr_msb;
  logic             rd_msb;
  logic             latched;
  logic             arm;
  logic             load_req;
  logic             rd_hi;
  logic             rd_last;

  assign acc_new = ctl_access(bus.wdata);

  // Latch commands leave the mode alone
  assign arm      = bus.ctrl_wr && (acc_new != acc_latch);
  assign mode_cur = arm ? ctl_mode(bus.wdata) : mode_q;

  // Count complete after the single byte, or after the MSB in word format
  assign load_req = bus.cnt_wr && ((acc_q == acc_lsb) || (acc_q == acc_msb) ||
                                   ((acc_q == acc_word) && wr_msb));

  // --------------------------------------------------
  // Read path
  // --------------------------------------------------
  assign rd_src    = latched ? latch_q : count;
  assign rd_hi     = (acc_q == acc_msb) || ((acc_q == acc_word) && rd_msb);
  assign rd_last   = (acc_q != acc_word) || rd_msb;
  assign bus.rdata = rd_hi ? rd_src[cnt_w-1:data_w] : rd_src[data_w-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      mode_q  <= mode0_terminal;
      acc_q   <= acc_latch;
      wr_msb  <= 1'b0;
      rd_msb  <= 1'b0;
      latched <= 1'b0;
    end else if (bus.ctrl_wr) begin
      if (arm) begin
        mode_q  <= ctl_mode(bus.wdata);
        acc_q   <= acc_new;
        wr_msb  <= 1'b0;
        rd_msb  <= 1'b0;
        latched <= 1'b0;
      end else begin
        // A second latch before the reads is ignored
        latched <= 1'b1;
      end
    end else if (bus.cnt_wr) begin
      if (acc_q == acc_word) begin
        wr_msb <= !wr_msb;
      end
    end else if (bus.cnt_rd) begin
      if (acc_q == acc_word) begin
        rd_msb <= !rd_msb;
      end
      if (latched && rd_last) begin
        latched <= 1'b0;
      end
    end
  end

  // Snapshot and initial count bytes
  always_ff @(posedge clk) begin
    if (bus.ctrl_wr && !arm && !latched) begin
      latch_q <= count;
    end
    if (bus.cnt_wr) begin
      case (acc_q)
        acc_lsb:  init_q <= {{(cnt_w-data_w){1'b0}}, bus.wdata};
        acc_msb:  init_q <= {bus.wdata, {data_w{1'b0}}};
        acc_word: begin
          if (wr_msb) begin
            init_q[cnt_w-1:data_w] <= bus.wdata;
          end else begin
            init_q[data_w-1:0] <= bus.wdata;
          end
        end
        default: ;
      endcase
    end
  end

  pit_count_unit cnt0 (
    .clk      (clk),
    .rst      (rst),
    .tick     (tick),
    .gate     (gate),
    .mode     (mode_cur),
    .arm      (arm),
    .load_req (load_req),
    .init     (init_q),
    .count    (count),
    .out      (out)
  );

endmodule

/* verilog/pit_count_unit.sv */
`timescale 1ns/1ns

module pit_count_unit import pit_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             tick,
  input  logic             gate,
  input  pit_mode_e        mode,
  input  logic             arm,
  input  logic             load_req,
  input  logic [cnt_w-1:0] init,
  output logic [cnt_w-1:0] count,
  output logic             out
);

  logic gate_q;
  logic trig;
  logic trig_now;
  logic pending;
  logic loaded;
  logic running;
  logic at_one;
  logic half_end;

  // Rising edge seen since the last tick, or on this clock
  assign trig_now = trig || (gate && !gate_q);
  assign at_one   = (count == cnt_w'(1));
  assign half_end = (count == cnt_w'(1)) || (count == cnt_w'(2));

  always_ff @(posedge clk) begin
    if (rst) begin
      gate_q <= 1'b0;
      trig   <= 1'b0;
    end else begin
      gate_q <= gate;
      if (arm || tick) begin
        trig <= 1'b0;
      end else if (gate && !gate_q) begin
        trig <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Counting step, one per tick
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      count   <= '0;
      out     <= 1'b1;
      pending <= 1'b0;
      loaded  <= 1'b0;
      running <= 1'b0;
    end else if (arm) begin
      // Mode 0 starts low, all others high
      out     <= (mode != mode0_terminal);
      pending <= 1'b0;
      loaded  <= 1'b0;
      running <= 1'b0;
    end else begin
      if (tick) begin
        case (mode)
          mode0_terminal: begin
            if (pending) begin
              count   <= init;
              out     <= 1'b0;
              running <= 1'b1;
              pending <= 1'b0;
            end else if (running && gate) begin
              count <= count - cnt_w'(1);
              if (at_one) begin
                out     <= 1'b1;
                running <= 1'b0;
              end
            end
          end
          mode1_oneshot: begin
            if (trig_now && loaded) begin
              count   <= init;
              out     <= 1'b0;
              running <= 1'b1;
              pending <= 1'b0;
            end else if (running) begin
              count <= count - cnt_w'(1);
              if (at_one) begin
                out     <= 1'b1;
                running <= 1'b0;
              end
            end
          end
          mode2_rate: begin
            if (pending || (running && !gate)) begin
              // Gate low keeps reloading
              count   <= init;
              out     <= 1'b1;
              running <= 1'b1;
              pending <= 1'b0;
            end else if (running) begin
              if (at_one) begin
                count <= init;
                out   <= 1'b1;
              end else begin
                count <= count - cnt_w'(1);
                out   <= (count != cnt_w'(2));
              end
            end
          end
          mode3_square: begin
            if (pending || (running && !gate)) begin
              count   <= init;
              out     <= 1'b1;
              running <= 1'b1;
              pending <= 1'b0;
            end else if (running) begin
              if (half_end) begin
                count <= init;
                out   <= !out;
              end else begin
                count <= count - cnt_w'(2);
              end
            end
          end
          mode4_soft_strobe: begin
            out <= 1'b1;
            if (pending) begin
              count   <= init;
              running <= 1'b1;
              pending <= 1'b0;
            end else if (running && gate) begin
              count <= count - cnt_w'(1);
              if (at_one) begin
                out     <= 1'b0;
                running <= 1'b0;
              end
            end
          end
          mode5_hard_strobe: begin
            out <= 1'b1;
            if (trig_now && loaded) begin
              count   <= init;
              running <= 1'b1;
              pending <= 1'b0;
            end else if (running) begin
              count <= count - cnt_w'(1);
              if (at_one) begin
                out     <= 1'b0;
                running <= 1'b0;
              end
            end
          end
          default: ;
        endcase
      end
      // New count waits for the next tick
      if (load_req) begin
        pending <= 1'b1;
        loaded  <= 1'b1;
      end
    end
  end

endmodule

/* verilog/pit_pkg.sv */
package pit_pkg;

  // Sizes
  localparam int num_chan = 3;
  localparam int cnt_w    = 16;
  localparam int data_w   = 8;
  localparam int addr_w   = 2;

  // Count registers sit at 0..2, control word at 3
  localparam logic [addr_w-1:0] addr_ctrl = 2'd3;

  // --------------------------------------------------
  // Control word encodings
  // --------------------------------------------------
  typedef enum logic [2:0] {
    mode0_terminal    = 3'd0,
    mode1_oneshot     = 3'd1,
    mode2_rate        = 3'd2,
    mode3_square      = 3'd3,
    mode4_soft_strobe = 3'd4,
    mode5_hard_strobe = 3'd5
  } pit_mode_e;

  typedef enum logic [1:0] {
    acc_latch = 2'd0,
    acc_lsb   = 2'd1,
    acc_msb   = 2'd2,
    acc_word  = 2'd3
  } pit_access_e;

  // Channel select in bits 7:6
  function automatic logic [1:0] ctl_sel(input logic [data_w-1:0] cw);
    return cw[7:6];
  endfunction

  // Access format in bits 5:4
  function automatic pit_access_e ctl_access(input logic [data_w-1:0] cw);
    return pit_access_e'(cw[5:4]);
  endfunction

  // Mode in bits 3:1 with codes 6 and 7 aliasing modes 2 and 3
  function automatic pit_mode_e ctl_mode(input logic [data_w-1:0] cw);
    logic [2:0] m;
    m = cw[3:1];
    if (m[2] && m[1]) begin
      m[2] = 1'b0;
    end
    return pit_mode_e'(m);
  endfunction

  // Bit 0 selects BCD counting and has no effect

endpackage

/* verilog/pit_top.sv */
`timescale 1ns/1ns

module pit_top import pit_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  logic [addr_w-1:0]   wb_adr,
  input  logic [data_w-1:0]   wb_dat_i,
  output logic [data_w-1:0]   wb_dat_o,
  output logic                wb_ack,
  input  logic [num_chan-1:0] tick,
  input  logic [num_chan-1:0] gate,
  output logic [num_chan-1:0] out
);

  pit_chan_if chif [num_chan] ();

  pit_bus bus0 (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack   (wb_ack),
    .ch       (chif)
  );

  // --------------------------------------------------
  // Counter channels
  // --------------------------------------------------
  pit_channel chan0 (
    .clk  (clk),
    .rst  (rst),
    .bus  (chif[0]),
    .tick (tick[0]),
    .gate (gate[0]),
    .out  (out[0])
  );

  pit_channel chan1 (
    .clk  (clk),
    .rst  (rst),
    .bus  (chif[1]),
    .tick (tick[1]),
    .gate (gate[1]),
    .out  (out[1])
  );

  pit_channel chan2 (
    .clk  (clk),
    .rst  (rst),
    .bus  (chif[2]),
    .tick (tick[2]),
    .gate (gate[2]),
    .out  (out[2])
  );

endmodule
